/* verilog/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    localparam int addr_width = 32;
    localparam int word_width = 32;
    localparam int word_bytes = 4;
    localparam int line_words = 4;
    localparam int line_count = 64;

    localparam int byte_sel_width = $clog2(word_bytes);
    localparam int word_sel_width = $clog2(line_words);
    localparam int offset_width   = byte_sel_width + word_sel_width;    // 4 bits.
    localparam int index_width    = $clog2(line_count);                 // 6 bits.
    localparam int tag_width      = addr_width - index_width - offset_width;

    typedef logic [word_width-1:0] word_t;
    typedef logic [word_bytes-1:0] strb_t;
    typedef logic [tag_width-1:0] tag_t;
    typedef logic [index_width-1:0] index_t;

    // word 0 sits in the low bits.
    typedef logic [line_words-1:0][word_width-1:0] line_t;

    // byte address without the offset within a line.
    typedef logic [addr_width-offset_width-1:0] line_addr_t;

    typedef struct packed {
        tag_t                      tag;
        index_t                    index;
        logic [word_sel_width-1:0] word_sel;
        logic [byte_sel_width-1:0] byte_off;
    } dcache_addr_fields_t;

    // same 32 bits, seen flat or split into cache fields.
    typedef union packed {
        logic [addr_width-1:0] flat;
        dcache_addr_fields_t   fields;
    } dcache_addr_u;

    typedef struct packed {
        dcache_addr_u addr;
        logic         write;
        strb_t        strb;
        word_t        wdata;
    } dcache_req_t;

    typedef struct packed {
        logic  write;
        word_t rdata;
    } dcache_rsp_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

endpackage

`default_nettype wire

/* verilog/dcache_req_stage.sv */
`default_nettype none

module dcache_req_stage (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    req_valid,
    input  dcache_pkg::dcache_req_t req,
    input  logic                    stall,
    output logic                    ready,
    output dcache_pkg::index_t      rd_index,
    output logic                    s1_valid,
    output dcache_pkg::dcache_req_t s1_req
);

    logic accept;

    assign ready  = ~stall;
    assign accept = req_valid & ready;

    // arrays read in parallel with the stage one register.
    assign rd_index = stall ? s1_req.addr.fields.index : req.addr.fields.index;

    always_ff @(posedge CLK) begin
        if (RST) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= accept;    // drops while stalled.
        end
    end

    // held through a miss, lookup still needs it.
    always_ff @(posedge CLK) begin
        if (accept) begin
            s1_req <= req;
        end
    end

endmodule

`default_nettype wire

/* verilog/dcache_arrays.sv */
`default_nettype none

module dcache_arrays (
    input  logic                   CLK,
    input  logic                   RST,
    input  dcache_pkg::index_t     rd_index,
    output dcache_pkg::tag_entry_t rd_entry,
    output dcache_pkg::line_t      rd_line,
    input  logic                   wr_en,
    input  dcache_pkg::index_t     wr_index,
    input  dcache_pkg::tag_entry_t wr_entry,
    input  dcache_pkg::line_t      wr_line
);

    dcache_pkg::tag_t  tag_mem   [dcache_pkg::line_count];
    logic              dirty_mem [dcache_pkg::line_count];
    dcache_pkg::line_t data_mem  [dcache_pkg::line_count];

    logic [dcache_pkg::line_count-1:0] valid_q;

    logic             rd_valid_q;
    logic             rd_dirty_q;
    dcache_pkg::tag_t rd_tag_q;

    // read returns the old contents on a same-index write.
    always_ff @(posedge CLK) begin
        if (wr_en) begin
            tag_mem[wr_index]   <= wr_entry.tag;
            dirty_mem[wr_index] <= wr_entry.dirty;
            data_mem[wr_index]  <= wr_line;
        end
        rd_tag_q   <= tag_mem[rd_index];
        rd_dirty_q <= dirty_mem[rd_index];
        rd_line    <= data_mem[rd_index];
    end

    // valid bits in flops so reset can clear them.
    always_ff @(posedge CLK) begin
        if (RST) begin
            valid_q    <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            if (wr_en) begin
                valid_q[wr_index] <= wr_entry.valid;
            end
            rd_valid_q <= valid_q[rd_index];
        end
    end

    always_comb begin
        rd_entry.valid = rd_valid_q;
        rd_entry.dirty = rd_dirty_q;    // stale when invalid.
        rd_entry.tag   = rd_tag_q;
    end

endmodule

`default_nettype wire

/* verilog/dcache_lookup.sv */
`default_nettype none

module dcache_lookup (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    s1_valid,
    input  dcache_pkg::dcache_req_t s1_req,
    input  dcache_pkg::tag_entry_t  rd_entry,
    input  dcache_pkg::line_t       rd_line,
    output logic                    wr_en,
    output dcache_pkg::index_t      wr_index,
    output dcache_pkg::tag_entry_t  wr_entry,
    output dcache_pkg::line_t       wr_line,
    output logic                    stall,
    output logic                    miss_start,
    output dcache_pkg::tag_entry_t  victim_entry,
    output dcache_pkg::line_t       victim_line,
    output dcache_pkg::line_addr_t  miss_addr,
    input  logic                    refill_done,
    input  dcache_pkg::line_t       refill_line,
    output logic                    rsp_valid,
    output dcache_pkg::dcache_rsp_t rsp
);

    function automatic dcache_pkg::word_t merge_word(
        input dcache_pkg::word_t old_w,
        input dcache_pkg::word_t new_w,
        input dcache_pkg::strb_t strb
    );
        dcache_pkg::word_t res;
        res = old_w;
        for (int i = 0; i < dcache_pkg::word_bytes; i++) begin
            if (strb[i]) begin
                res[i*8 +: 8] = new_w[i*8 +: 8];
            end
        end
        return res;
    endfunction

    dcache_pkg::index_t                    s1_index;
    logic [dcache_pkg::word_sel_width-1:0] s1_wsel;

    logic                   fwd_valid;
    logic                   fwd_hit;
    dcache_pkg::index_t     fwd_index;
    dcache_pkg::tag_entry_t fwd_entry;
    dcache_pkg::line_t      fwd_line;

    dcache_pkg::tag_entry_t cur_entry;
    dcache_pkg::line_t      cur_line;
    dcache_pkg::line_t      base_line;
    dcache_pkg::line_t      merged_line;
    dcache_pkg::word_t      old_word;
    dcache_pkg::word_t      new_word;

    logic hit;
    logic lookup_hit;
    logic lookup_miss;
    logic miss_busy;

    logic              s2_valid;
    logic              s2_fill;
    logic              s2_write;
    dcache_pkg::word_t s2_data;
    logic              rsp_fill;

    assign s1_index = s1_req.addr.fields.index;
    assign s1_wsel  = s1_req.addr.fields.word_sel;

    // the array missed last cycle's write, take it from the flops.
    assign fwd_hit   = fwd_valid && (fwd_index == s1_index);
    assign cur_entry = fwd_hit ? fwd_entry : rd_entry;
    assign cur_line  = fwd_hit ? fwd_line : rd_line;

    assign hit         = cur_entry.valid && (cur_entry.tag == s1_req.addr.fields.tag);
    assign lookup_hit  = s1_valid && hit;
    assign lookup_miss = s1_valid && !hit;
    assign stall       = lookup_miss || miss_busy;

    assign base_line = refill_done ? refill_line : cur_line;
    assign old_word  = base_line[s1_wsel];
    assign new_word  = merge_word(old_word, s1_req.wdata, s1_req.strb);

    always_comb begin
        merged_line = base_line;
        if (s1_req.write) begin
            merged_line[s1_wsel] = new_word;
        end
    end

    // hit stores and refills share the one write port.
    assign wr_en    = (lookup_hit && s1_req.write) || refill_done;
    assign wr_index = s1_index;
    assign wr_line  = merged_line;

    always_comb begin
        wr_entry.valid = 1'b1;
        wr_entry.dirty = s1_req.write;    // clean refill for a load.
        wr_entry.tag   = s1_req.addr.fields.tag;
    end

    // one cycle long, s1_valid drops behind the stall.
    assign miss_start   = lookup_miss;
    assign victim_entry = cur_entry;
    assign victim_line  = cur_line;
    assign miss_addr    = s1_req.addr.flat[dcache_pkg::addr_width-1:dcache_pkg::offset_width];

    always_ff @(posedge CLK) begin
        if (RST) begin
            fwd_valid <= 1'b0;
            miss_busy <= 1'b0;
            s2_valid  <= 1'b0;
            s2_fill   <= 1'b0;
            rsp_valid <= 1'b0;
            rsp_fill  <= 1'b0;
        end else begin
            fwd_valid <= wr_en;
            if (lookup_miss) begin
                miss_busy <= 1'b1;
            end else if (rsp_fill) begin
                miss_busy <= 1'b0;    // reopen after the miss response.
            end
            s2_valid  <= lookup_hit || refill_done;
            s2_fill   <= refill_done;
            rsp_valid <= s2_valid;
            rsp_fill  <= s2_fill;
        end
    end

    always_ff @(posedge CLK) begin
        fwd_index <= wr_index;
        fwd_entry <= wr_entry;
        fwd_line  <= wr_line;
        s2_write  <= s1_req.write;
        s2_data   <= s1_req.write ? new_word : old_word;    // stores return the new word.
        rsp.write <= s2_write;
        rsp.rdata <= s2_data;
    end

endmodule

`default_nettype wire

/* verilog/dcache_miss_ctrl.sv */
`default_nettype none

module dcache_miss_ctrl (
    input  logic                   CLK,
    input  logic                   RST,
    input  logic                   miss_start,
    input  dcache_pkg::tag_entry_t victim_entry,
    input  dcache_pkg::line_t      victim_line,
    input  dcache_pkg::line_addr_t miss_addr,
    output logic                   refill_done,
    output dcache_pkg::line_t      refill_line,
    output logic                   wb_valid,
    output dcache_pkg::line_addr_t wb_addr,
    output dcache_pkg::line_t      wb_line,
    input  logic                   wb_done,
    output logic                   fill_req,
    output dcache_pkg::line_addr_t fill_addr,
    input  logic                   fill_valid,
    input  dcache_pkg::line_t      fill_line
);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_wb   = 2'd1;
    localparam logic [1:0] st_wait = 2'd2;
    localparam logic [1:0] st_fill = 2'd3;

    logic [1:0]             state;
    logic                   need_wb;
    logic                   start;
    logic                   fill_end;
    dcache_pkg::line_addr_t victim_addr;

    // victim shares the index with the missing line.
    assign victim_addr = {victim_entry.tag, miss_addr[dcache_pkg::index_width-1:0]};
    assign need_wb     = victim_entry.valid && victim_entry.dirty;

    assign start    = (state == st_idle) && miss_start;
    assign fill_end = (state == st_fill) && fill_valid;

    assign wb_valid = (state == st_wb);    // single cycle state.
    assign fill_req = (state == st_fill);

    always_ff @(posedge CLK) begin
        if (RST) begin
            state       <= st_idle;
            refill_done <= 1'b0;
        end else begin
            refill_done <= fill_end;
            case (state)
                st_idle: begin
                    if (miss_start) begin
                        state <= need_wb ? st_wb : st_fill;
                    end
                end
                st_wb: begin
                    state <= st_wait;
                end
                st_wait: begin
                    if (wb_done) begin
                        state <= st_fill;
                    end
                end
                st_fill: begin
                    if (fill_valid) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (start) begin
            wb_addr   <= victim_addr;
            wb_line   <= victim_line;
            fill_addr <= miss_addr;
        end
        if (fill_end) begin
            refill_line <= fill_line;
        end
    end

endmodule

`default_nettype wire

/* verilog/dcache_top.sv */
`default_nettype none

module dcache_top (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    req_valid,
    input  dcache_pkg::dcache_req_t req,
    output logic                    ready,
    output logic                    rsp_valid,
    output dcache_pkg::dcache_rsp_t rsp,
    output logic                    wb_valid,
    output dcache_pkg::line_addr_t  wb_addr,
    output dcache_pkg::line_t       wb_line,
    input  logic                    wb_done,
    output logic                    fill_req,
    output dcache_pkg::line_addr_t  fill_addr,
    input  logic                    fill_valid,
    input  dcache_pkg::line_t       fill_line
);

    logic                    stall;
    dcache_pkg::index_t      rd_index;
    logic                    s1_valid;
    dcache_pkg::dcache_req_t s1_req;
    dcache_pkg::tag_entry_t  rd_entry;
    dcache_pkg::line_t       rd_line;
    logic                    wr_en;
    dcache_pkg::index_t      wr_index;
    dcache_pkg::tag_entry_t  wr_entry;
    dcache_pkg::line_t       wr_line;
    logic                    miss_start;
    dcache_pkg::tag_entry_t  victim_entry;
    dcache_pkg::line_t       victim_line;
    dcache_pkg::line_addr_t  miss_addr;
    logic                    refill_done;
    dcache_pkg::line_t       refill_line;

    dcache_req_stage u_req_stage (
        .CLK      (CLK),
        .RST      (RST),
        .req_valid(req_valid),
        .req      (req),
        .stall    (stall),
        .ready    (ready),
        .rd_index (rd_index),
        .s1_valid (s1_valid),
        .s1_req   (s1_req)
    );

    dcache_arrays u_arrays (
        .CLK     (CLK),
        .RST     (RST),
        .rd_index(rd_index),
        .rd_entry(rd_entry),
        .rd_line (rd_line),
        .wr_en   (wr_en),
        .wr_index(wr_index),
        .wr_entry(wr_entry),
        .wr_line (wr_line)
    );

    dcache_lookup u_lookup (
        .CLK         (CLK),
        .RST         (RST),
        .s1_valid    (s1_valid),
        .s1_req      (s1_req),
        .rd_entry    (rd_entry),
        .rd_line     (rd_line),
        .wr_en       (wr_en),
        .wr_index    (wr_index),
        .wr_entry    (wr_entry),
        .wr_line     (wr_line),
        .stall       (stall),
        .miss_start  (miss_start),
        .victim_entry(victim_entry),
        .victim_line (victim_line),
        .miss_addr   (miss_addr),
        .refill_done (refill_done),
        .refill_line (refill_line),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp)
    );

    dcache_miss_ctrl u_miss_ctrl (
        .CLK         (CLK),
        .RST         (RST),
        .miss_start  (miss_start),
        .victim_entry(victim_entry),
        .victim_line (victim_line),
        .miss_addr   (miss_addr),
        .refill_done (refill_done),
        .refill_line (refill_line),
        .wb_valid    (wb_valid),
        .wb_addr     (wb_addr),
        .wb_line     (wb_line),
        .wb_done     (wb_done),
        .fill_req    (fill_req),
        .fill_addr   (fill_addr),
        .fill_valid  (fill_valid),
        .fill_line   (fill_line)
    );

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
`default_nettype none

module tb_clock (
    output logic CLK
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;    // 100 ns period.
    end

endmodule

`default_nettype wire

/* dv/dcache_properties.sv */
`default_nettype none

module dcache_properties (
    input logic CLK,
    input logic RST,
    input logic req_valid,
    input logic ready,
    input logic rsp_valid,
    input logic wb_valid,
    input logic fill_req,
    input logic fill_valid,
    input logic miss_start,
    input logic refill_done
);

    timeunit 1ns;
    timeprecision 1ps;

    wb_valid_pulse: assert property (@(posedge CLK) disable iff (RST) wb_valid |=> !wb_valid)
        else $error("wb_valid high for more than one cycle");

    // refill write, then one response cycle, then ready again.
    miss_rsp_pulse: assert property (@(posedge CLK) disable iff (RST)
        $past(refill_done, 3) |-> ($past(rsp_valid) && !rsp_valid && ready))
        else $error("miss response not a single cycle followed by ready");

    miss_start_pulse: assert property (@(posedge CLK) disable iff (RST)
        miss_start |=> !miss_start)
        else $error("miss_start high for more than one cycle");

    refill_done_pulse: assert property (@(posedge CLK) disable iff (RST)
        refill_done |=> !refill_done)
        else $error("refill_done high for more than one cycle");

    fill_req_held: assert property (@(posedge CLK) disable iff (RST)
        (fill_req && !fill_valid) |=> fill_req)
        else $error("fill_req dropped before fill_valid");

    busy_not_ready: assert property (@(posedge CLK) disable iff (RST)
        (fill_req || wb_valid) |-> !ready)
        else $error("ready high while the next level is busy");

    // accept followed by no stall on the lookup cycle.
    hit_latency: assert property (@(posedge CLK) disable iff (RST)
        ($past(req_valid && ready, 3) && $past(ready, 2)) |-> rsp_valid)
        else $error("hit response missing two cycles after acceptance");

endmodule

`default_nettype wire

/* dv/dcache_tb.sv */
`default_nettype none

module dcache_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_reqs          = 600;
    localparam int worst_miss_cycles = 20;
    localparam int timeout_cycles    = num_reqs * worst_miss_cycles;

    logic                    CLK;
    logic                    RST;
    logic                    req_valid;
    dcache_pkg::dcache_req_t req;
    logic                    ready;
    logic                    rsp_valid;
    dcache_pkg::dcache_rsp_t rsp;
    logic                    wb_valid;
    dcache_pkg::line_addr_t  wb_addr;
    dcache_pkg::line_t       wb_line;
    logic                    wb_done;
    logic                    fill_req;
    dcache_pkg::line_addr_t  fill_addr;
    logic                    fill_valid;
    dcache_pkg::line_t       fill_line;

    logic [7:0]               model_mem [logic [31:0]];    // byte addressed reference.
    dcache_pkg::word_t        next_mem [logic [29:0]];     // word addressed next level.
    logic                     stored_lines [dcache_pkg::line_addr_t];
    dcache_pkg::dcache_rsp_t  expect_q [$];
    dcache_pkg::dcache_rsp_t  exp_rsp;
    dcache_pkg::dcache_addr_u last_addr;
    int                       cycles = 0;
    int                       sent;
    logic                     taken;

    tb_clock u_clock (.CLK(CLK));

    dcache_top DUT (.*);

    bind dcache_top dcache_properties u_properties (.*);

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_rsp(input string name, input dcache_pkg::dcache_rsp_t exp,
                             input dcache_pkg::dcache_rsp_t act);
        if (act !== exp) begin
            stop_with_error($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_line(input string name, input dcache_pkg::line_t exp,
                              input dcache_pkg::line_t act);
        if (act !== exp) begin
            stop_with_error($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    // every address bit reaches the pattern.
    function automatic dcache_pkg::word_t init_word(input logic [29:0] word_addr);
        return {word_addr[13:0], word_addr[29:12]} ^ 32'hc3a5_96e1;
    endfunction

    function automatic logic [7:0] model_byte(input logic [31:0] addr);
        dcache_pkg::word_t w;
        if (model_mem.exists(addr)) begin
            return model_mem[addr];
        end
        w = init_word(addr[31:2]);
        return w[addr[1:0]*8 +: 8];
    endfunction

    function automatic dcache_pkg::word_t model_word(input logic [31:0] base);
        dcache_pkg::word_t w;
        for (int b = 0; b < dcache_pkg::word_bytes; b++) begin
            w[b*8 +: 8] = model_byte(base + 32'(b));
        end
        return w;
    endfunction

    function automatic dcache_pkg::line_t model_line(input dcache_pkg::line_addr_t la);
        dcache_pkg::line_t l;
        for (int w = 0; w < dcache_pkg::line_words; w++) begin
            l[w] = model_word({la, 2'(w), 2'b00});
        end
        return l;
    endfunction

    function automatic dcache_pkg::word_t next_word(input logic [29:0] word_addr);
        if (next_mem.exists(word_addr)) begin
            return next_mem[word_addr];
        end
        return init_word(word_addr);
    endfunction

    // 4 indexes with 3 tags each and frequent line reuse.
    task automatic make_request(output dcache_pkg::dcache_req_t r);
        dcache_pkg::dcache_addr_u a;
        a = last_addr;
        if ($urandom_range(0, 2) != 0) begin
            a.fields.tag   = dcache_pkg::tag_t'($urandom_range(0, 2) * 32'h15a3 + 32'h2c1);
            a.fields.index = dcache_pkg::index_t'($urandom_range(0, 3));
        end
        a.fields.word_sel = 2'($urandom_range(0, 3));
        a.fields.byte_off = 2'b00;
        last_addr = a;
        r.addr  = a;
        r.write = 1'($urandom_range(0, 1));
        r.strb  = dcache_pkg::strb_t'($urandom_range(0, 15));
        r.wdata = $urandom();
    endtask

    task automatic record_request(input dcache_pkg::dcache_req_t r);
        logic [31:0]             base;
        dcache_pkg::dcache_rsp_t exp;
        base = {r.addr.flat[31:2], 2'b00};
        if (r.write) begin
            for (int b = 0; b < dcache_pkg::word_bytes; b++) begin
                if (r.strb[b]) begin
                    model_mem[base + 32'(b)] = r.wdata[b*8 +: 8];
                end
            end
            stored_lines[r.addr.flat[31:4]] = 1'b1;
        end
        exp.write = r.write;
        exp.rdata = model_word(base);    // stores answer with the merged word.
        expect_q.push_back(exp);
    endtask

    task automatic serve_write_back();
        dcache_pkg::line_addr_t addr;
        dcache_pkg::line_t      line;
        addr = wb_addr;
        line = wb_line;
        if (!stored_lines.exists(addr)) begin
            stop_with_error($sformatf("Write-back of line %h with no store since its refill",
                                      addr));
        end else begin
            check_line("write-back line", model_line(addr), line);
            stored_lines.delete(addr);
            for (int w = 0; w < dcache_pkg::line_words; w++) begin
                next_mem[{addr, 2'(w)}] = line[w];
            end
            repeat ($urandom_range(1, 5)) @(negedge CLK);
            wb_done = 1'b1;
            @(negedge CLK);
            wb_done = 1'b0;
        end
    endtask

    task automatic serve_fill();
        dcache_pkg::line_t line;
        repeat ($urandom_range(1, 5)) @(negedge CLK);
        for (int w = 0; w < dcache_pkg::line_words; w++) begin
            line[w] = next_word({fill_addr, 2'(w)});
        end
        fill_line  = line;
        fill_valid = 1'b1;
        @(negedge CLK);
        fill_valid = 1'b0;
    endtask

    initial begin
        wb_done    = 1'b0;
        fill_valid = 1'b0;
        fill_line  = '0;
        forever begin
            @(negedge CLK);
            if (wb_valid === 1'b1) begin
                serve_write_back();
            end else if (fill_req === 1'b1) begin
                serve_fill();
            end
        end
    end

    always @(negedge CLK) begin
        if (!RST && rsp_valid === 1'b1) begin
            if (expect_q.size() == 0) begin
                stop_with_error("Response arrived with no request outstanding");
            end else begin
                exp_rsp = expect_q.pop_front();
                check_rsp(exp_rsp.write ? "store response" : "load response", exp_rsp, rsp);
            end
        end
    end

    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (cycles > timeout_cycles) begin
            stop_with_error($sformatf("Timeout after %0d cycles with %0d responses outstanding",
                                      cycles, expect_q.size()));
        end
    end

    initial begin
        void'($urandom(1));
        RST       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        last_addr = '0;
        sent      = 0;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;
        // ready is stable from one falling edge to the next rising edge.
        while (sent < num_reqs) begin
            if (!req_valid && ($urandom_range(0, 3) != 0)) begin
                make_request(req);
                req_valid = 1'b1;
            end
            taken = req_valid && ready;
            if (taken) begin
                record_request(req);
                sent = sent + 1;
            end
            @(negedge CLK);
            if (taken) begin
                req_valid = 1'b0;
            end
        end
        while (expect_q.size() != 0) begin
            @(negedge CLK);
        end
        repeat (4) @(negedge CLK);
        if (ready && !fill_req && !wb_valid) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            stop_with_error("Cache still busy after the last response");
        end
    end

endmodule

`default_nettype wire

/* compile.f */
verilog/dcache_pkg.sv
verilog/dcache_req_stage.sv
verilog/dcache_arrays.sv
verilog/dcache_lookup.sv
verilog/dcache_miss_ctrl.sv
verilog/dcache_top.sv
dv/tb_clock.sv
dv/dcache_properties.sv
dv/dcache_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module dcache_tb \
    -Mdir obj_dir -f compile.f > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vdcache_tb > sim.log 2>&1 ; cat sim.log
grep -q "^Finished with no errors$" sim.log && exit 0 || exit 1
